// File: logic/kbd_lcd_pkg.sv
package kbd_lcd_pkg;

  typedef logic [7:0] scan_code_t;

  typedef struct packed {
    logic       valid;  // one-cycle strobe
    logic [7:0] ascii;
  } key_event_t;

  // set-DDRAM-address instruction layout
  typedef struct packed {
    logic       set_addr;
    logic       line;
    logic [1:0] pad;
    logic [3:0] col;
  } lcd_addr_t;

  typedef union packed {
    logic [7:0] chr;
    lcd_addr_t  addr;
  } lcd_word_u;

  typedef struct packed {
    logic      cmd;  // 1 = instruction, 0 = data
    lcd_word_u word;
  } lcd_bus_t;

  localparam scan_code_t SC_BREAK  = 8'hf0;
  localparam scan_code_t SC_LSHIFT = 8'h12;
  localparam scan_code_t SC_RSHIFT = 8'h59;
  localparam scan_code_t SC_CAPS   = 8'h58;
  localparam scan_code_t SC_SPACE  = 8'h29;

  localparam logic [7:0] ASCII_LOWER_A = 8'h61;
  localparam logic [7:0] ASCII_UPPER_A = 8'h41;
  localparam logic [7:0] ASCII_ZERO    = 8'h30;
  localparam logic [7:0] ASCII_SPACE   = 8'h20;

endpackage

// File: logic/ps2_line_filter.sv
module ps2_line_filter #(
  parameter int FILTER_DEPTH = 8
) (
  input  logic clk,
  input  logic rst,
  input  logic line,
  output logic level
);

  logic [FILTER_DEPTH-1:0] hist;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      hist  <= '1;  // line idles high
      level <= 1'b1;
    end else begin
      hist <= {hist[FILTER_DEPTH-2:0], line};
      if (&hist) begin
        level <= 1'b1;
      end else if (~|hist) begin
        level <= 1'b0;
      end
    end
  end

endmodule

// File: logic/ps2_frame_rx.sv
module ps2_frame_rx import kbd_lcd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       byte_valid,
  output scan_code_t scan
);

  logic        clk_q;
  logic        fall;
  logic [10:0] frame;
  logic [3:0]  bit_cnt;

  assign fall = clk_q & ~ps2_clk;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      clk_q      <= 1'b1;
      bit_cnt    <= '0;
      byte_valid <= 1'b0;
    end else begin
      clk_q      <= ps2_clk;
      byte_valid <= 1'b0;
      if (fall) begin
        if (bit_cnt == 4'd10) begin  // stop bit
          bit_cnt    <= '0;
          byte_valid <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end
    end
  end

  // start bit ends up in bit 0, stop bit in bit 10
  always_ff @(posedge clk) begin
    if (fall) begin
      frame <= {ps2_data, frame[10:1]};
    end
  end

  assign scan = frame[8:1];  // parity and stop ignored

endmodule

// File: logic/key_decoder.sv
module key_decoder import kbd_lcd_pkg::*; (
  input  logic       clk,
  input  logic       rst,
  input  logic       byte_valid,
  input  scan_code_t scan,
  output key_event_t key
);

  // scan codes of a to z in alphabet order
  localparam scan_code_t LETTER_SCAN [26] = '{
    8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43,
    8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d,
    8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a
  };

  logic       break_pending;
  logic       shift_held;
  logic       caps_on;
  logic       letter_hit;
  logic [4:0] letter_idx;
  logic       digit_hit;
  logic [3:0] digit_val;
  logic [7:0] letter_base;

  always_comb begin
    letter_hit = 1'b0;
    letter_idx = '0;
    for (int i = 0; i < 26; i++) begin
      if (scan == LETTER_SCAN[i]) begin
        letter_hit = 1'b1;
        letter_idx = 5'(i);
      end
    end
  end

  // top row first, then keypad
  always_comb begin
    digit_hit = 1'b1;
    digit_val = '0;
    case (scan)
      8'h45, 8'h70: digit_val = 4'd0;
      8'h16, 8'h69: digit_val = 4'd1;
      8'h1e, 8'h72: digit_val = 4'd2;
      8'h26, 8'h7a: digit_val = 4'd3;
      8'h25, 8'h6b: digit_val = 4'd4;
      8'h2e, 8'h73: digit_val = 4'd5;
      8'h36, 8'h74: digit_val = 4'd6;
      8'h3d, 8'h6c: digit_val = 4'd7;
      8'h3e, 8'h75: digit_val = 4'd8;
      8'h46, 8'h7d: digit_val = 4'd9;
      default:      digit_hit = 1'b0;
    endcase
  end

  assign letter_base = (caps_on == shift_held) ? ASCII_LOWER_A : ASCII_UPPER_A;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      break_pending <= 1'b0;
      shift_held    <= 1'b0;
      caps_on       <= 1'b0;
      key           <= '0;
    end else begin
      key.valid <= 1'b0;
      if (byte_valid) begin
        if (scan == SC_BREAK) begin
          break_pending <= 1'b1;
        end else begin
          break_pending <= 1'b0;
          if (scan == SC_LSHIFT || scan == SC_RSHIFT) begin
            shift_held <= ~break_pending;  // make sets, break clears
          end else if (break_pending) begin
            if (scan == SC_CAPS) begin
              caps_on <= ~caps_on;
            end else if (letter_hit) begin
              key <= '{valid: 1'b1, ascii: letter_base + {3'b000, letter_idx}};
            end else if (digit_hit) begin
              key <= '{valid: 1'b1, ascii: ASCII_ZERO + {4'b0000, digit_val}};
            end else if (scan == SC_SPACE) begin
              key <= '{valid: 1'b1, ascii: ASCII_SPACE};
            end
          end
        end
      end
    end
  end

endmodule

// File: logic/cursor_counter.sv
module cursor_counter #(
  parameter int LCD_COLS = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          advance,
  output logic [$clog2(2*LCD_COLS)-1:0] pos
);

  localparam int POS_W = $clog2(2 * LCD_COLS);

  // two lines of LCD_COLS each
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pos <= '0;
    end else if (advance) begin
      if (pos == POS_W'(2 * LCD_COLS - 1)) begin
        pos <= '0;  // wrap to top left
      end else begin
        pos <= pos + 1'b1;
      end
    end
  end

endmodule

// File: logic/lcd_write_fsm.sv
module lcd_write_fsm import kbd_lcd_pkg::*; #(
  parameter int LCD_COLS = 16
) (
  input  logic                          clk,
  input  logic                          rst,
  input  key_event_t                    key,
  input  logic                          busy,
  input  logic [$clog2(2*LCD_COLS)-1:0] pos,
  output lcd_bus_t                      lcd,
  output logic                          en,
  output logic                          advance
);

  localparam int POS_W = $clog2(2 * LCD_COLS);

  typedef enum logic [2:0] {
    idle,
    addr_wait,
    addr_strobe,
    char_wait,
    char_strobe
  } state_t;

  state_t     state;
  logic [7:0] chr_q;
  logic       line_start;

  assign line_start = (pos == '0) || (pos == POS_W'(LCD_COLS));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= idle;
    end else begin
      case (state)
        idle:        if (key.valid) state <= line_start ? addr_wait : char_wait;
        addr_wait:   if (!busy) state <= addr_strobe;
        addr_strobe: state <= char_wait;
        char_wait:   if (!busy) state <= char_strobe;
        char_strobe: state <= idle;
        default:     state <= idle;
      endcase
    end
  end

  // word held steady until its strobe
  always_ff @(posedge clk) begin
    if (state == idle && key.valid) begin
      chr_q <= key.ascii;
      if (line_start) begin
        lcd.cmd                <= 1'b1;
        lcd.word.addr.set_addr <= 1'b1;
        lcd.word.addr.line     <= (pos >= POS_W'(LCD_COLS));
        lcd.word.addr.pad      <= 2'b00;
        lcd.word.addr.col      <= 4'd0;
      end else begin
        lcd.cmd      <= 1'b0;
        lcd.word.chr <= key.ascii;
      end
    end else if (state == addr_strobe) begin
      lcd.cmd      <= 1'b0;
      lcd.word.chr <= chr_q;
    end
  end

  assign en      = (state == addr_strobe) || (state == char_strobe);
  assign advance = (state == char_strobe);

endmodule

// File: logic/kbd_lcd_top.sv
module kbd_lcd_top import kbd_lcd_pkg::*; #(
  parameter int FILTER_DEPTH = 8,
  parameter int LCD_COLS     = 16
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       busy,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic       en,
  output logic       cmd,
  output logic [7:0] data
);

  logic                          ps2_clk_f;
  logic                          ps2_data_f;
  logic                          byte_valid;
  scan_code_t                    scan;
  key_event_t                    key;
  lcd_bus_t                      lcd;
  logic                          advance;
  logic [$clog2(2*LCD_COLS)-1:0] pos;

  ps2_line_filter #(.FILTER_DEPTH(FILTER_DEPTH)) ps2_clk_filter_inst (
    .clk, .rst, .line(ps2_clk), .level(ps2_clk_f)
  );

  ps2_line_filter #(.FILTER_DEPTH(FILTER_DEPTH)) ps2_data_filter_inst (
    .clk, .rst, .line(ps2_data), .level(ps2_data_f)
  );

  ps2_frame_rx ps2_frame_rx_inst (
    .clk, .rst, .ps2_clk(ps2_clk_f), .ps2_data(ps2_data_f), .byte_valid, .scan
  );

  key_decoder key_decoder_inst (.clk, .rst, .byte_valid, .scan, .key);

  lcd_write_fsm #(.LCD_COLS(LCD_COLS)) lcd_write_fsm_inst (
    .clk, .rst, .key, .busy, .pos, .lcd, .en, .advance
  );

  cursor_counter #(.LCD_COLS(LCD_COLS)) cursor_counter_inst (.clk, .rst, .advance, .pos);

  assign cmd  = lcd.cmd;
  assign data = lcd.word.chr;

endmodule

// File: dv/kbd_lcd_tb.sv
module kbd_lcd_tb;

  localparam int LCD_COLS      = 16;
  localparam int PS2_HALF      = 40;    // system clocks per PS/2 clock half period
  localparam int DRAIN_TIMEOUT = 3000;

  // one table row holds the scan bytes to send and the LCD words they produce
  typedef struct packed {
    logic [2:0]      n_bytes;
    logic [5:0][7:0] bytes;
    logic [1:0]      n_words;
    logic [1:0][8:0] words;  // {cmd, data}
  } row_t;

  logic clk;
  logic rst;
  logic busy;
  logic ps2_clk;
  logic ps2_data;
  logic en;
  logic cmd;
  logic [7:0] data;

  row_t        table_q[$];
  logic [8:0]  exp_q[$];
  logic [8:0]  exp_word;
  int unsigned hold_q[$];
  int          char_count;
  int          words_total;
  int          en_count;
  int          mismatch_count;
  int          other_errors;
  int unsigned busy_hold;
  int unsigned busy_left;

  kbd_lcd_top #(.FILTER_DEPTH(8), .LCD_COLS(LCD_COLS)) kbd_lcd_top_inst (
    .clk, .rst, .busy, .ps2_clk, .ps2_data, .en, .cmd, .data
  );

  always #2 clk = ~clk;

  // display model holds busy 0 to 6 cycles after each write
  always @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      busy_left <= 0;
    end else if (en) begin
      busy_hold = 0;
      if (hold_q.size() != 0) begin
        busy_hold = hold_q.pop_front();
      end
      busy_left <= busy_hold;
      busy      <= (busy_hold != 0);
    end else if (busy_left > 1) begin
      busy_left <= busy_left - 1;
    end else begin
      busy_left <= 0;
      busy      <= 1'b0;
    end
  end

  always @(posedge clk) begin
    if (!rst && en) begin
      en_count++;
      assert (!busy) else begin
        other_errors++;
        $display("Error at %0t: en pulsed while the display was busy", $time);
      end
      assert (exp_q.size() != 0) else begin
        other_errors++;
        $display("Error at %0t: en pulsed with no word expected (cmd %0b data %02h)",
                 $time, cmd, data);
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        assert ({cmd, data} == exp_word) else begin
          mismatch_count++;
          $display("Mismatch at %0t: got cmd %0b data %02h, expected cmd %0b data %02h",
                   $time, cmd, data, exp_word[8], exp_word[7:0]);
        end
      end
    end
  end

  // first of the n bytes in the top bits of seq; chr 0 means no output
  task automatic add_row(input int n, input logic [47:0] seq, input logic [7:0] chr);
    row_t r;
    r = '0;
    r.n_bytes = 3'(n);
    for (int i = 0; i < n; i++) begin
      r.bytes[i] = seq[(n - 1 - i) * 8 +: 8];
    end
    if (chr != 8'h00) begin
      if (char_count % (2 * LCD_COLS) == 0) begin
        r.words[r.n_words] = 9'h180;  // line 0, column 0
        r.n_words = r.n_words + 1;
      end else if (char_count % (2 * LCD_COLS) == LCD_COLS) begin
        r.words[r.n_words] = 9'h1c0;  // line 1, column 0
        r.n_words = r.n_words + 1;
      end
      r.words[r.n_words] = {1'b0, chr};
      r.n_words = r.n_words + 1;
      char_count++;
    end
    words_total += r.n_words;
    table_q.push_back(r);
  endtask

  // start, 8 data bits LSB first, odd parity, stop
  task automatic send_byte(input logic [7:0] b);
    logic [10:0] frame;
    frame = {1'b1, ~^b, b, 1'b0};
    for (int i = 0; i < 11; i++) begin
      ps2_data <= frame[i];
      repeat (PS2_HALF) @(posedge clk);
      ps2_clk <= 1'b0;
      repeat (PS2_HALF) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    ps2_data <= 1'b1;
    repeat (60) @(posedge clk);
  endtask

  task automatic wait_drained(input int row_idx);
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < DRAIN_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      other_errors++;
      $display("Error at %0t: timed out, %0d LCD words of row %0d were never written",
               $time, exp_q.size(), row_idx);
      exp_q.delete();
    end
  endtask

  task automatic build_table();
    logic [7:0] letters [26];
    letters = '{8'h1c, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2b, 8'h34, 8'h33, 8'h43,
                8'h3b, 8'h42, 8'h4b, 8'h3a, 8'h31, 8'h44, 8'h4d, 8'h15, 8'h2d,
                8'h1b, 8'h2c, 8'h3c, 8'h2a, 8'h1d, 8'h22, 8'h35, 8'h1a};
    add_row(3, 'h1cf01c, "a");
    add_row(4, 'h1232f032, "B");  // left shift held
    add_row(2, 'hf012, 8'h00);
    add_row(3, 'h21f021, "c");
    add_row(4, 'h5923f023, "D");  // right shift held
    add_row(2, 'hf059, 8'h00);
    add_row(3, 'h58f058, 8'h00);  // caps on
    add_row(3, 'h24f024, "E");
    add_row(4, 'h122bf02b, "f");  // caps and shift cancel
    add_row(2, 'hf012, 8'h00);
    add_row(3, 'h58f058, 8'h00);  // caps off
    add_row(3, 'h34f034, "g");
    add_row(3, 'h16f016, "1");
    add_row(3, 'h45f045, "0");
    add_row(3, 'h46f046, "9");
    add_row(3, 'h69f069, "1");    // keypad
    add_row(3, 'h7df07d, "9");
    add_row(3, 'h70f070, "0");
    add_row(3, 'h29f029, " ");
    add_row(3, 'h05f005, 8'h00);  // unmapped
    add_row(1, 'h1c, 8'h00);
    add_row(1, 'h1a, 8'h00);
    // whole alphabet crosses both line starts and the wrap
    for (int i = 0; i < 26; i++) begin
      add_row(3, {24'h0, letters[i], 8'hf0, letters[i]}, 8'h61 + 8'(i));
    end
  endtask

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    busy           = 1'b0;
    ps2_clk        = 1'b1;
    ps2_data       = 1'b1;
    char_count     = 0;
    words_total    = 0;
    en_count       = 0;
    mismatch_count = 0;
    other_errors   = 0;
    void'($urandom(32'h90c4));
    build_table();
    for (int i = 0; i < words_total; i++) begin
      hold_q.push_back($urandom_range(6, 0));
    end
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (50) @(posedge clk);  // en must stay low here
    for (int r = 0; r < table_q.size(); r++) begin
      for (int w = 0; w < table_q[r].n_words; w++) begin
        exp_q.push_back(table_q[r].words[w]);
      end
      for (int b = 0; b < table_q[r].n_bytes; b++) begin
        send_byte(table_q[r].bytes[b]);
      end
      wait_drained(r);
      repeat (100) @(posedge clk);
    end
    assert (en_count == words_total) else begin
      other_errors++;
      $display("Error: %0d LCD writes seen, %0d expected", en_count, words_total);
    end
    $display("Errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
    if (mismatch_count == 0 && other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: tb.f
logic/kbd_lcd_pkg.sv
logic/ps2_line_filter.sv
logic/ps2_frame_rx.sv
logic/key_decoder.sv
logic/cursor_counter.sv
logic/lcd_write_fsm.sv
logic/kbd_lcd_top.sv
dv/kbd_lcd_tb.sv

// File: Bender.yml
package:
  name: kbd_lcd

sources:
  - logic/kbd_lcd_pkg.sv
  - logic/ps2_line_filter.sv
  - logic/ps2_frame_rx.sv
  - logic/key_decoder.sv
  - logic/cursor_counter.sv
  - logic/lcd_write_fsm.sv
  - logic/kbd_lcd_top.sv
  - target: simulation
    files:
      - dv/kbd_lcd_tb.sv
